// File: perf_pkg.sv
// Performance monitor package with event indices, CSR map and shared bus types
`default_nettype none

package perf_pkg;

  // Bank geometry
  localparam int NUM_CNT = 11;   // One counter per fixed event
  localparam int CNT_W   = 64;   // Full counter width
  localparam int DATA_W  = 32;   // CSR word, half a counter
  localparam int ADDR_W  = 12;   // CSR address space
  localparam int IDX_W   = 4;    // Enough for NUM_CNT entries

  // CSR map, low words then high words
  localparam logic [ADDR_W-1:0] CSR_CNT_LO_BASE = 12'hB03;  // Low word of counter 0
  localparam logic [ADDR_W-1:0] CSR_CNT_HI_BASE = 12'hB83;  // High word of counter 0
  localparam logic [ADDR_W-1:0] CSR_CNT_SPAN    = ADDR_W'(NUM_CNT);  // Mapped words per half

  // Event slots, also the counter index
  typedef enum logic [IDX_W-1:0] {
    EV_DCACHE_MISS      = 4'd0,
    EV_DCACHE_HIT       = 4'd1,
    EV_FLUSHING         = 4'd2,   // Level, counts every flush cycle
    EV_FLUSH_DONE       = 4'd3,   // Falling edge of flushing
    EV_AMO_DONE         = 4'd4,   // Falling edge of amo
    EV_CYCLE            = 4'd5,   // Free running
    EV_WR_HIT_UNIQUE    = 4'd6,
    EV_WR_HIT_SHARED    = 4'd7,
    EV_WR_MISS          = 4'd8,
    EV_CLEAN_INVAL_HIT  = 4'd9,
    EV_CLEAN_INVAL_MISS = 4'd10
  } perf_event_e;

  // Raw level inputs from the data cache
  typedef struct packed {
    logic miss;
    logic hit;
    logic flushing;
    logic amo;               // High while an AMO is in flight
    logic write_hit_unique;
    logic write_hit_shared;
    logic write_miss;
    logic clean_inval_hit;
    logic clean_inval_miss;
  } perf_dcache_ev_t;

  // CSR request, read is implied every cycle
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
  } perf_csr_req_t;

  // Write command from the CSR decode into the bank
  typedef struct packed {
    logic              clear;  // Any write request, freezes and clears all
    logic              valid;  // Write hits a mapped half-word
    logic [IDX_W-1:0]  idx;    // Target counter
    logic              hi;     // Upper half selected
    logic [DATA_W-1:0] wdata;
  } perf_cnt_wr_t;

  // Whole bank as one packed vector
  typedef logic [NUM_CNT-1:0][CNT_W-1:0] perf_cnt_arr_t;

endpackage

`default_nettype wire

// File: perf_event_capture.sv
// Event capture turning raw cache levels into one increment bit per counter
`default_nettype none

module perf_event_capture (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire perf_pkg::perf_dcache_ev_t       dcache_ev_i,
  output logic [perf_pkg::NUM_CNT-1:0]         events_o
);

  // Previous levels for edge detection
  logic flushing_q;
  logic amo_q;

  // Falling edges high in the first low cycle only
  logic flush_done;
  logic amo_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flushing_q <= 1'b0;
      amo_q      <= 1'b0;
    end else begin
      flushing_q <= dcache_ev_i.flushing;
      amo_q      <= dcache_ev_i.amo;
    end
  end

  assign flush_done = flushing_q & ~dcache_ev_i.flushing;
  assign amo_done   = amo_q & ~dcache_ev_i.amo;

  // Map each source onto its enum slot
  always_comb begin
    events_o = '0;
    events_o[perf_pkg::EV_DCACHE_MISS]      = dcache_ev_i.miss;
    events_o[perf_pkg::EV_DCACHE_HIT]       = dcache_ev_i.hit;
    events_o[perf_pkg::EV_FLUSHING]         = dcache_ev_i.flushing;
    events_o[perf_pkg::EV_FLUSH_DONE]       = flush_done;
    events_o[perf_pkg::EV_AMO_DONE]         = amo_done;
    events_o[perf_pkg::EV_CYCLE]            = 1'b1;  // Counts every clock
    events_o[perf_pkg::EV_WR_HIT_UNIQUE]    = dcache_ev_i.write_hit_unique;
    events_o[perf_pkg::EV_WR_HIT_SHARED]    = dcache_ev_i.write_hit_shared;
    events_o[perf_pkg::EV_WR_MISS]          = dcache_ev_i.write_miss;
    events_o[perf_pkg::EV_CLEAN_INVAL_HIT]  = dcache_ev_i.clean_inval_hit;
    events_o[perf_pkg::EV_CLEAN_INVAL_MISS] = dcache_ev_i.clean_inval_miss;
  end

  // Flush done only in a low cycle that follows a high one
  a_flush_done_edge: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    events_o[perf_pkg::EV_FLUSH_DONE] |-> !dcache_ev_i.flushing && $past(dcache_ev_i.flushing)
  ) else $error("flush done outside a falling edge of flushing");

endmodule

`default_nettype wire

// File: perf_counter_bank.sv
// Counter bank with eleven 64-bit event counters, freeze-and-clear and half-word load
`default_nettype none

module perf_counter_bank (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          debug_mode_i,
  input  wire logic [perf_pkg::NUM_CNT-1:0]  events_i,
  input  wire perf_pkg::perf_cnt_wr_t        cnt_wr_i,
  output perf_pkg::perf_cnt_arr_t            counters_o
);

  perf_pkg::perf_cnt_arr_t cnt_q;
  perf_pkg::perf_cnt_arr_t cnt_d;

  // Bank is frozen at zero in debug or on any write request
  logic freeze;

  assign freeze = debug_mode_i | cnt_wr_i.clear;

  // Next state of the bank
  always_comb begin
    cnt_d = cnt_q;

    for (int i = 0; i < perf_pkg::NUM_CNT; i++) begin
      if (freeze) begin
        cnt_d[i] = '0;
      end else begin
        // Event bit is the increment itself
        cnt_d[i] = cnt_q[i] + {{(perf_pkg::CNT_W-1){1'b0}}, events_i[i]};
      end
    end

    // Written half-word overrides the clear
    if (cnt_wr_i.valid) begin
      if (cnt_wr_i.hi) begin
        cnt_d[cnt_wr_i.idx][perf_pkg::CNT_W-1:perf_pkg::DATA_W] = cnt_wr_i.wdata;
      end else begin
        cnt_d[cnt_wr_i.idx][perf_pkg::DATA_W-1:0] = cnt_wr_i.wdata;
      end
    end
  end

  // Counter state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign counters_o = cnt_q;  // Read side sees registered values only

  // Mapped write always comes with the clear from the CSR decode
  a_valid_implies_clear: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_wr_i.valid |-> cnt_wr_i.clear
  ) else $error("mapped write without clear");

endmodule

`default_nettype wire

// File: perf_csr_port.sv
// CSR port decoding counter addresses for reads, writes and access errors
`default_nettype none

module perf_csr_port (
  input  wire perf_pkg::perf_csr_req_t     csr_req_i,
  input  wire perf_pkg::perf_cnt_arr_t     counters_i,
  output perf_pkg::perf_cnt_wr_t           cnt_wr_o,
  output logic [perf_pkg::DATA_W-1:0]      rdata_o,
  output logic                             rd_err_o,
  output logic                             wr_err_o
);

  // Offsets from each base, wrap makes addresses below a base huge
  logic [perf_pkg::ADDR_W-1:0] lo_off;
  logic [perf_pkg::ADDR_W-1:0] hi_off;

  logic lo_hit;   // Low word window
  logic hi_hit;   // High word window
  logic mapped;

  logic [perf_pkg::IDX_W-1:0] idx;
  logic [perf_pkg::CNT_W-1:0] sel_cnt;  // Addressed counter

  assign lo_off = csr_req_i.addr - perf_pkg::CSR_CNT_LO_BASE;
  assign hi_off = csr_req_i.addr - perf_pkg::CSR_CNT_HI_BASE;

  assign lo_hit = lo_off < perf_pkg::CSR_CNT_SPAN;
  assign hi_hit = hi_off < perf_pkg::CSR_CNT_SPAN;
  assign mapped = lo_hit | hi_hit;

  // Windows never overlap so one offset is enough
  assign idx = lo_hit ? lo_off[perf_pkg::IDX_W-1:0] : hi_off[perf_pkg::IDX_W-1:0];

  // Read mux, zero when unmapped
  always_comb begin
    sel_cnt = '0;
    rdata_o = '0;
    if (mapped) begin
      sel_cnt = counters_i[idx];
      if (hi_hit) begin
        rdata_o = sel_cnt[perf_pkg::CNT_W-1:perf_pkg::DATA_W];
      end else begin
        rdata_o = sel_cnt[perf_pkg::DATA_W-1:0];
      end
    end
  end

  // Read implied every cycle
  assign rd_err_o = ~mapped;
  assign wr_err_o = csr_req_i.we & ~mapped;

  // Write command back into the bank
  always_comb begin
    cnt_wr_o.clear = csr_req_i.we;            // Any write freezes the bank
    cnt_wr_o.valid = csr_req_i.we & mapped;
    cnt_wr_o.idx   = idx;
    cnt_wr_o.hi    = hi_hit;
    cnt_wr_o.wdata = csr_req_i.wdata;
  end

  // Error reads must not leak counter data
  always_comb begin
    a_err_rdata_zero: assert final (!(rd_err_o && (rdata_o != '0)))
      else $error("rdata nonzero on unmapped read");
  end

endmodule

`default_nettype wire

// File: perf_counters.sv
// Data cache performance monitor top joining event capture, counter bank and CSR port
`default_nettype none

module perf_counters (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          debug_mode_i,   // Freezes and clears all counters
  input  wire perf_pkg::perf_csr_req_t       csr_req_i,
  input  wire perf_pkg::perf_dcache_ev_t     dcache_ev_i,
  output logic [perf_pkg::DATA_W-1:0]        rdata_o,
  output logic                               rd_err_o,
  output logic                               wr_err_o
);

  // One increment bit per counter
  logic [perf_pkg::NUM_CNT-1:0] events;

  // Bank contents toward the read mux
  perf_pkg::perf_cnt_arr_t counters;

  // Decoded write, fed back into the bank
  perf_pkg::perf_cnt_wr_t cnt_wr;

  perf_event_capture u_capture (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dcache_ev_i (dcache_ev_i),
    .events_o    (events)
  );

  perf_counter_bank u_bank (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .debug_mode_i (debug_mode_i),
    .events_i     (events),
    .cnt_wr_i     (cnt_wr),
    .counters_o   (counters)
  );

  // Purely combinational decode
  perf_csr_port u_csr (
    .csr_req_i  (csr_req_i),
    .counters_i (counters),
    .cnt_wr_o   (cnt_wr),
    .rdata_o    (rdata_o),
    .rd_err_o   (rd_err_o),
    .wr_err_o   (wr_err_o)
  );

endmodule

`default_nettype wire

// File: tb_perf_clock.sv
// Testbench clock and reset source, 100 ns period with reset held for four cycles
`default_nettype none

module tb_perf_clock (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_NS    = 50;   // Half of the 100 ns period
  localparam int RST_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // Release a little after the last reset edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #10 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_perf_checker.sv
// Scoreboard that models the eleven counters from the DUT inputs and checks every read
`default_nettype none

module tb_perf_checker (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      debug_mode_i,
  input  wire perf_pkg::perf_csr_req_t   csr_req_i,
  input  wire perf_pkg::perf_dcache_ev_t dcache_ev_i,
  input  wire logic [31:0]               rdata_i,
  input  wire logic                      rd_err_i,
  input  wire logic                      wr_err_i,
  input  wire logic                      exp_vld_i,    // Row carries its own expected word
  input  wire logic [31:0]               exp_rdata_i,
  output int                             err_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [63:0] model_cnt [perf_pkg::NUM_CNT];  // Reference counters
  logic        flushing_q;                      // Previous levels for the edge events
  logic        amo_q;
  int          err_cnt = 0;

  assign err_cnt_o = err_cnt;

  // Address onto window and counter, idx only meaningful on a hit
  task automatic decode(input logic [11:0] addr, output logic lo, output logic hi,
                        output int idx);
    lo  = (addr >= perf_pkg::CSR_CNT_LO_BASE) &&
          (addr < perf_pkg::CSR_CNT_LO_BASE + 12'(perf_pkg::NUM_CNT));
    hi  = (addr >= perf_pkg::CSR_CNT_HI_BASE) &&
          (addr < perf_pkg::CSR_CNT_HI_BASE + 12'(perf_pkg::NUM_CNT));
    idx = lo ? int'(addr - perf_pkg::CSR_CNT_LO_BASE) : int'(addr - perf_pkg::CSR_CNT_HI_BASE);
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    err_cnt++;
    $display("Fail %s at %0t ns: got %h, expected %h", name, $time, got, exp);
  endtask

  // Same-cycle read path and error strobes
  task automatic compare_outputs();
    logic        lo;
    logic        hi;
    int          idx;
    logic [31:0] exp_rdata;
    logic        unmapped;
    decode(csr_req_i.addr, lo, hi, idx);
    unmapped  = !(lo || hi);
    exp_rdata = '0;                                   // Unmapped reads as zero
    if (lo) exp_rdata = model_cnt[idx][31:0];
    else if (hi) exp_rdata = model_cnt[idx][63:32];
    if (rdata_i !== exp_rdata) mismatch("rdata_o", rdata_i, exp_rdata);
    if (exp_vld_i && (rdata_i !== exp_rdata_i)) mismatch("rdata_o (table)", rdata_i, exp_rdata_i);
    if (rd_err_i !== unmapped) mismatch("rd_err_o", 32'(rd_err_i), 32'(unmapped));
    if (wr_err_i !== (csr_req_i.we && unmapped)) begin
      mismatch("wr_err_o", 32'(wr_err_i), 32'(csr_req_i.we && unmapped));
    end
  endtask

  // State the DUT will hold after the coming rising edge
  task automatic step_model();
    logic [perf_pkg::NUM_CNT-1:0] ev;
    logic                         lo;
    logic                         hi;
    int                           idx;
    ev = '0;
    ev[perf_pkg::EV_DCACHE_MISS]      = dcache_ev_i.miss;
    ev[perf_pkg::EV_DCACHE_HIT]       = dcache_ev_i.hit;
    ev[perf_pkg::EV_FLUSHING]         = dcache_ev_i.flushing;
    ev[perf_pkg::EV_FLUSH_DONE]       = flushing_q && !dcache_ev_i.flushing;  // Falling edge
    ev[perf_pkg::EV_AMO_DONE]         = amo_q && !dcache_ev_i.amo;
    ev[perf_pkg::EV_CYCLE]            = 1'b1;
    ev[perf_pkg::EV_WR_HIT_UNIQUE]    = dcache_ev_i.write_hit_unique;
    ev[perf_pkg::EV_WR_HIT_SHARED]    = dcache_ev_i.write_hit_shared;
    ev[perf_pkg::EV_WR_MISS]          = dcache_ev_i.write_miss;
    ev[perf_pkg::EV_CLEAN_INVAL_HIT]  = dcache_ev_i.clean_inval_hit;
    ev[perf_pkg::EV_CLEAN_INVAL_MISS] = dcache_ev_i.clean_inval_miss;
    for (int i = 0; i < perf_pkg::NUM_CNT; i++) begin
      if (debug_mode_i || csr_req_i.we) model_cnt[i] = '0;   // Freeze and clear
      else model_cnt[i] = model_cnt[i] + 64'(ev[i]);
    end
    decode(csr_req_i.addr, lo, hi, idx);
    if (csr_req_i.we && lo) model_cnt[idx][31:0] = csr_req_i.wdata;
    if (csr_req_i.we && hi) model_cnt[idx][63:32] = csr_req_i.wdata;
    flushing_q = dcache_ev_i.flushing;
    amo_q      = dcache_ev_i.amo;
  endtask

  // Falling edge, inputs settled since the 10 ns drive point
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      foreach (model_cnt[i]) model_cnt[i] = '0;
      flushing_q = 1'b0;
      amo_q      = 1'b0;
    end
    compare_outputs();
    if (rst_ni) step_model();
  end

endmodule

`default_nettype wire

// File: tb_perf_counters.sv
// Testbench top driving the cache performance monitor from a stimulus table
`default_nettype none

module tb_perf_counters;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          PERIOD_NS  = 100;
  localparam int          DRIVE_NS   = 10;       // Input skew after the rising edge
  localparam int          RST_CYCLES = 4;
  localparam logic [11:0] LO         = perf_pkg::CSR_CNT_LO_BASE;
  localparam logic [11:0] HI         = perf_pkg::CSR_CNT_HI_BASE;
  localparam logic [8:0]  FLUSH      = 9'h040;   // flushing field of the event struct
  localparam logic [8:0]  AMO        = 9'h020;
  localparam logic [8:0]  LEVEL_MASK = 9'h19F;   // All level events except flushing and amo

  typedef struct packed {
    logic        debug;
    logic        we;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic [8:0]  ev;          // Same bit order as perf_dcache_ev_t
    logic        chk;         // exp_rdata is meaningful
    logic [31:0] exp_rdata;
  } stim_row_t;

  logic                      clk;
  logic                      rst_n;
  logic                      debug_mode;
  perf_pkg::perf_csr_req_t   csr_req;
  perf_pkg::perf_dcache_ev_t dcache_ev;
  logic [31:0]               rdata;
  logic                      rd_err;
  logic                      wr_err;
  logic                      exp_vld;
  logic [31:0]               exp_rdata;
  int                        err_cnt;

  stim_row_t   rows_q[$];
  logic [31:0] rng_state  = 32'd74417;
  logic        rows_ready = 1'b0;
  longint      watchdog_ns;

  tb_perf_clock u_clock (.clk_o(clk), .rst_no(rst_n));

  perf_counters dut0 (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .debug_mode_i (debug_mode),
    .csr_req_i    (csr_req),
    .dcache_ev_i  (dcache_ev),
    .rdata_o      (rdata),
    .rd_err_o     (rd_err),
    .wr_err_o     (wr_err)
  );

  tb_perf_checker u_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .debug_mode_i (debug_mode),
    .csr_req_i    (csr_req),
    .dcache_ev_i  (dcache_ev),
    .rdata_i      (rdata),
    .rd_err_i     (rd_err),
    .wr_err_i     (wr_err),
    .exp_vld_i    (exp_vld),
    .exp_rdata_i  (exp_rdata),
    .err_cnt_o    (err_cnt)
  );

  function automatic logic [31:0] next_xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_row(input logic dbg, input logic we, input logic [11:0] addr,
                         input logic [31:0] wdata, input logic [8:0] ev,
                         input logic chk, input logic [31:0] exp);
    stim_row_t r;
    r = '{debug: dbg, we: we, addr: addr, wdata: wdata, ev: ev, chk: chk, exp_rdata: exp};
    rows_q.push_back(r);
  endtask

  task automatic build_table();
    // Reset values, the running cycle count left to the checker
    for (int i = 0; i < perf_pkg::NUM_CNT; i++) begin
      add_row(0, 0, LO + 12'(i), 0, 0, i != int'(perf_pkg::EV_CYCLE), 0);
      add_row(0, 0, HI + 12'(i), 0, 0, 1, 0);
    end
    // Random level soak
    for (int i = 0; i < 24; i++) begin
      rng_state = next_xorshift(rng_state);
      add_row(0, 0, LO + 12'(i % perf_pkg::NUM_CNT), 0, rng_state[8:0] & LEVEL_MASK, 0, 0);
    end
    repeat (4) add_row(0, 0, LO + 12'd3, 0, FLUSH, 1, 0);
    add_row(0, 0, LO + 12'd3, 0, 0, 1, 0);   // Falling edge, bump not visible yet
    add_row(0, 0, LO + 12'd3, 0, 0, 1, 1);
    add_row(0, 0, LO + 12'd2, 0, 0, 1, 4);   // Four high cycles of flushing
    repeat (3) add_row(0, 0, LO + 12'd4, 0, AMO, 1, 0);
    add_row(0, 0, LO + 12'd4, 0, 0, 1, 0);
    repeat (2) add_row(0, 0, LO + 12'd4, 0, 0, 1, 1);   // Once only
    // Half-word loads
    add_row(0, 1, LO + 12'd1, 32'hA5A5_1234, 0, 0, 0);
    add_row(0, 0, LO + 12'd1, 0, 0, 1, 32'hA5A5_1234);
    add_row(0, 0, HI + 12'd1, 0, 0, 1, 0);
    add_row(0, 0, LO + 12'd0, 0, 0, 1, 0);
    add_row(0, 0, LO + 12'd5, 0, 0, 1, 3);   // Cycle restarted at the write
    add_row(0, 1, HI + 12'd8, 32'hDEAD_BEEF, 0, 0, 0);
    add_row(0, 0, HI + 12'd8, 0, 0, 1, 32'hDEAD_BEEF);
    add_row(0, 0, LO + 12'd8, 0, 0, 1, 0);
    add_row(0, 0, LO + 12'd1, 0, 0, 1, 0);   // Earlier load wiped by the second write
    // Debug freeze, first row still shows old values
    for (int i = 0; i < 5; i++) begin
      rng_state = next_xorshift(rng_state);
      add_row(1, 0, LO + 12'd5, 0, rng_state[8:0] & LEVEL_MASK, i > 0, 0);
    end
    for (int i = 0; i < 3; i++) add_row(0, 0, LO + 12'd5, 0, 0, 1, 32'(i));
    // Unmapped accesses
    add_row(0, 0, 12'hB0E, 0, 0, 1, 0);
    add_row(0, 0, 12'hB02, 0, 0, 1, 0);
    add_row(0, 0, 12'hB8E, 0, 0, 1, 0);
    add_row(0, 0, 12'h300, 0, 0, 1, 0);
    add_row(0, 1, 12'hB8E, 32'hFFFF_FFFF, 0, 1, 0);   // Still clears the bank
    add_row(0, 0, LO + 12'd5, 0, 0, 1, 0);
    add_row(0, 0, LO + 12'd5, 0, 0, 1, 1);
  endtask

  task automatic apply_row(input stim_row_t r);
    debug_mode    = r.debug;
    csr_req.addr  = r.addr;
    csr_req.we    = r.we;
    csr_req.wdata = r.wdata;
    dcache_ev     = perf_pkg::perf_dcache_ev_t'(r.ev);
    exp_vld       = r.chk;
    exp_rdata     = r.exp_rdata;
  endtask

  task automatic drive_idle();
    stim_row_t r;
    r      = '0;
    r.addr = LO;   // Mapped, keeps rd_err_o low
    apply_row(r);
  endtask

  initial begin
    wait (rows_ready);
    #(watchdog_ns);
    $display("Timeout: stimulus did not complete within %0d ns", watchdog_ns);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    drive_idle();
    build_table();
    watchdog_ns = longint'(rows_q.size() + 20 + RST_CYCLES) * PERIOD_NS;
    rows_ready  = 1'b1;
    wait (rst_n === 1'b1);
    foreach (rows_q[i]) begin
      @(posedge clk);
      #(DRIVE_NS);
      apply_row(rows_q[i]);
    end
    @(posedge clk);
    #(DRIVE_NS);
    drive_idle();
    @(posedge clk);
    #(DRIVE_NS);     // Past the checker's last compare
    $display("Error count: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
perf_pkg.sv
perf_event_capture.sv
perf_counter_bank.sv
perf_csr_port.sv
perf_counters.sv
tb_perf_clock.sv
tb_perf_checker.sv
tb_perf_counters.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the performance monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_perf_counters \
  -Mdir obj_dir -o tb_perf_counters

./obj_dir/tb_perf_counters > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
